/* tb.f */
m2k_pkg.sv
m2k_axi_lite_slave.sv
m2k_regmap.sv
m2k_spi_engine.sv
m2k_ctrl_top.sv
tb_clk_gen.sv
tb_m2k_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the control plane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module tb_m2k_ctrl -o sim_tb_m2k_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb_m2k_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

exit 0

/* tb_m2k_ctrl.sv */
// Testbench for the control plane top level
// AXI4-Lite host driver, converter and synthesizer SPI models,
// reference function, compare tasks and the test scenarios

`timescale 1ns/1ps

module tb_m2k_ctrl;

  import m2k_pkg::*;

  localparam int TIMEOUT = 400;

  logic              clk;
  logic              rst_n;
  logic              awvalid;
  logic              awready;
  logic [ADDR_W-1:0] awaddr;
  logic              wvalid;
  logic              wready;
  logic [31:0]       wdata;
  logic              bvalid;
  logic              bready;
  logic [1:0]        bresp;
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;
  logic              rvalid;
  logic              rready;
  logic [31:0]       rdata;
  logic [1:0]        rresp;
  logic [31:0]       gpio_in;
  logic [31:0]       gpio_out;
  logic [31:0]       gpio_tri;
  logic              adc_resetn;
  logic              power_en;
  logic              adc_csn;
  logic              pll_cs;
  logic              spi_clk;
  logic              sdio_out;
  logic              sdio_tri;
  logic              sdio_in;

  logic [15:0] lfsr_q;

  // Device model state
  logic [23:0] adc_sr;
  logic [15:0] adc_instr;
  int          adc_cnt;
  int          adc_frames;
  spi_word_u   adc_last;
  logic [23:0] pll_sr;
  int          pll_frames;
  spi_word_u   pll_last;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n));

  m2k_ctrl_top uut (
    .s_axi_aclk_i      (clk),
    .rst_n_i           (rst_n),
    .s_axi_awvalid_i   (awvalid),
    .s_axi_awready_o   (awready),
    .s_axi_awaddr_i    (awaddr),
    .s_axi_wvalid_i    (wvalid),
    .s_axi_wready_o    (wready),
    .s_axi_wdata_i     (wdata),
    .s_axi_bvalid_o    (bvalid),
    .s_axi_bready_i    (bready),
    .s_axi_bresp_o     (bresp),
    .s_axi_arvalid_i   (arvalid),
    .s_axi_arready_o   (arready),
    .s_axi_araddr_i    (araddr),
    .s_axi_rvalid_o    (rvalid),
    .s_axi_rready_i    (rready),
    .s_axi_rdata_o     (rdata),
    .s_axi_rresp_o     (rresp),
    .gpio_i_i          (gpio_in),
    .gpio_o_o          (gpio_out),
    .gpio_t_o          (gpio_tri),
    .ad9963_resetn_o   (adc_resetn),
    .en_power_analog_o (power_en),
    .ad9963_csn_o      (adc_csn),
    .adf4360_cs_o      (pll_cs),
    .spi_clk_o         (spi_clk),
    .spi_sdio_o        (sdio_out),
    .spi_sdio_t_o      (sdio_tri),
    .spi_sdio_i        (sdio_in));

  // **************************************************
  // Reference model and random numbers
  // **************************************************

  // Byte the converter returns for a read of addr
  function automatic logic [7:0] ref_read_byte(input logic [12:0] addr);
    return addr[7:0] ^ 8'hA5;
  endfunction

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic spi_word_u rand_frame();
    logic [31:0] r;
    r = rand_bits(SPI_FRAME_BITS);
    return r[SPI_FRAME_BITS-1:0];
  endfunction

  // **************************************************
  // Compare tasks
  // **************************************************

  task automatic abort_test(input string what);
    $display("%0t ns: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got,
                            input logic [1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %0b expected %0b", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_spi_word(input string name, input spi_word_u got,
                                input spi_word_u exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got 0x%06h expected 0x%06h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // **************************************************
  // SPI device models
  // **************************************************

  always @(negedge adc_csn) begin
    adc_cnt = 0;
    adc_sr  = '0;
  end

  always @(posedge spi_clk) begin
    if (!adc_csn) begin
      adc_sr  = {adc_sr[22:0], sdio_out};
      adc_cnt = adc_cnt + 1;
      if (adc_cnt == SPI_INSTR_BITS) begin
        adc_instr = adc_sr[15:0];
      end
    end
    if (!pll_cs) begin
      pll_sr = {pll_sr[22:0], sdio_out};
    end
  end

  always @(posedge adc_csn) begin
    adc_frames = adc_frames + 1;
    adc_last   = adc_sr;
  end

  always @(posedge pll_cs) begin
    pll_frames = pll_frames + 1;
    pll_last   = pll_sr;
  end

  // Converter answers a read after the instruction, MSB first
  always @(negedge spi_clk) begin
    logic [7:0] rd_byte;
    #1;
    if (!adc_csn && adc_instr[15] && adc_cnt >= SPI_INSTR_BITS && adc_cnt < SPI_FRAME_BITS) begin
      if (sdio_tri !== 1'b1) begin
        abort_test("converter drives the data line while the master still drives it");
      end
      rd_byte = ref_read_byte(adc_instr[12:0]);
      sdio_in = rd_byte[SPI_FRAME_BITS - 1 - adc_cnt];
    end
  end

  // **************************************************
  // AXI4-Lite host driver
  // **************************************************

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           input int stall, output logic [1:0] resp);
    int   t;
    logic hs;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Ready is sampled mid-cycle, the handshake completes on the next rising edge
    t  = 0;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk);
      hs = awready && wready;
      @(posedge clk);
      #1;
      t++;
      if (!hs && t > TIMEOUT) abort_test("write address and data handshake timed out");
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    t = 0;
    while (!bvalid) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) abort_test("write response never became valid");
    end
    resp = bresp;
    // Hold bready low and offer a read that must not be accepted
    araddr  = REG_ID;
    arvalid = 1'b1;
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #1;
      check_word("s_axi_bvalid_o", {31'd0, bvalid}, 32'd1);
      check_resp("s_axi_bresp_o", bresp, resp);
      check_word("s_axi_arready_o", {31'd0, arready}, 32'd0);
    end
    arvalid = 1'b0;
    bready  = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, input int stall,
                          output logic [31:0] data, output logic [1:0] resp);
    int   t;
    logic hs;
    araddr  = addr;
    arvalid = 1'b1;
    t  = 0;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk);
      hs = arready;
      @(posedge clk);
      #1;
      t++;
      if (!hs && t > TIMEOUT) abort_test("read address handshake timed out");
    end
    arvalid = 1'b0;
    t = 0;
    while (!rvalid) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) abort_test("read response never became valid");
    end
    data = rdata;
    resp = rresp;
    awaddr  = REG_GPIO_OUT;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #1;
      check_word("s_axi_rvalid_o", {31'd0, rvalid}, 32'd1);
      check_word("s_axi_rdata_o", rdata, data);
      check_resp("s_axi_rresp_o", rresp, resp);
      check_word("s_axi_awready_o", {31'd0, awready}, 32'd0);
      check_word("s_axi_wready_o", {31'd0, wready}, 32'd0);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    rready  = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic wait_spi_idle(output logic [31:0] stat);
    logic [1:0] resp;
    int         t;
    t = 0;
    axi_read(REG_SPI_STAT, 0, stat, resp);
    while (stat[0]) begin
      t++;
      if (t > TIMEOUT) abort_test("SPI engine stayed busy");
      axi_read(REG_SPI_STAT, 0, stat, resp);
    end
  endtask

  // **************************************************
  // Scenarios
  // **************************************************

  initial begin
    logic [31:0] data;
    logic [31:0] val;
    logic [1:0]  resp;
    spi_word_u   word;
    spi_word_u   busy_word;
    int          t;

    lfsr_q     = 16'd85;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    gpio_in    = '0;
    sdio_in    = 1'b0;
    adc_instr  = '0;
    adc_sr     = '0;
    pll_sr     = '0;
    adc_cnt    = 0;

    t = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) abort_test("reset was never released");
    end
    adc_frames = 0;
    pll_frames = 0;

    // Reset values
    check_word("chip selects", {30'd0, adc_csn, pll_cs}, 32'd3);
    check_word("spi_clk_o and spi_sdio_t_o", {30'd0, spi_clk, sdio_tri}, 32'd1);
    check_word("gpio_o_o", gpio_out, 32'd0);
    check_word("control pins", {30'd0, power_en, adc_resetn}, 32'd0);
    axi_read(REG_ID, 0, data, resp);
    check_word("REG_ID", data, CORE_ID);
    check_resp("REG_ID rresp", resp, RESP_OKAY);
    axi_read(REG_GPIO_TRI, 0, data, resp);
    check_word("REG_GPIO_TRI", data, 32'hFFFF_FFFF);
    check_word("chip selects", {30'd0, adc_csn, pll_cs}, 32'd3);

    // GPIO and control registers
    val = rand_bits(32);
    axi_write(REG_GPIO_OUT, val, 0, resp);
    check_resp("REG_GPIO_OUT bresp", resp, RESP_OKAY);
    check_word("gpio_o_o", gpio_out, val);
    axi_read(REG_GPIO_OUT, 0, data, resp);
    check_word("REG_GPIO_OUT", data, val);
    val = rand_bits(32);
    axi_write(REG_GPIO_TRI, val, 0, resp);
    check_word("gpio_t_o", gpio_tri, val);
    axi_read(REG_GPIO_TRI, 0, data, resp);
    check_word("REG_GPIO_TRI", data, val);
    val = rand_bits(2);
    axi_write(REG_CTRL, val, 0, resp);
    check_word("control pins", {30'd0, power_en, adc_resetn}, val);
    axi_read(REG_CTRL, 0, data, resp);
    check_word("REG_CTRL", data, val);

    gpio_in = rand_bits(32);
    t = 0;
    axi_read(REG_GPIO_IN, 0, data, resp);
    while (data !== gpio_in) begin
      t++;
      if (t > 10) abort_test("GPIO input never reached REG_GPIO_IN");
      axi_read(REG_GPIO_IN, 0, data, resp);
    end

    // Converter write
    word = rand_frame();
    word.adc.rw = 1'b0;
    axi_write(REG_SPI_CMD, {7'd0, 1'b0, word}, 0, resp);
    check_resp("REG_SPI_CMD bresp", resp, RESP_OKAY);
    wait_spi_idle(data);
    check_word("converter frames", adc_frames, 32'd1);
    check_word("synthesizer frames", pll_frames, 32'd0);
    check_spi_word("converter word", adc_last, word);

    // Synthesizer latch
    word = rand_frame();
    axi_write(REG_SPI_CMD, {7'd0, 1'b1, word}, 0, resp);
    wait_spi_idle(data);
    check_word("converter frames", adc_frames, 32'd1);
    check_word("synthesizer frames", pll_frames, 32'd1);
    check_spi_word("synthesizer word", pll_last, word);

    // The converter read releases the data byte, so it shifts in as zero
    word = rand_frame();
    word.adc.rw   = 1'b1;
    word.adc.data = 8'd0;
    axi_write(REG_SPI_CMD, {7'd0, 1'b0, word}, 0, resp);
    wait_spi_idle(data);
    check_word("converter frames", adc_frames, 32'd2);
    check_spi_word("converter read word", adc_last, word);
    check_word("REG_SPI_STAT rdata", {24'd0, data[15:8]},
               {24'd0, ref_read_byte(word.adc.addr)});

    // Error paths
    axi_read(5'h1C, 0, data, resp);
    check_resp("unmapped rresp", resp, RESP_SLVERR);
    check_word("unmapped rdata", data, 32'd0);
    axi_write(5'h1C, rand_bits(32), 0, resp);
    check_resp("unmapped bresp", resp, RESP_SLVERR);
    axi_write(REG_GPIO_IN, rand_bits(32), 0, resp);
    check_resp("REG_GPIO_IN bresp", resp, RESP_SLVERR);

    word = rand_frame();
    word.adc.rw = 1'b0;
    busy_word = ~word;
    axi_write(REG_SPI_CMD, {7'd0, 1'b0, word}, 0, resp);
    check_resp("REG_SPI_CMD bresp", resp, RESP_OKAY);
    axi_write(REG_SPI_CMD, {7'd0, 1'b1, busy_word}, 0, resp);
    check_resp("busy REG_SPI_CMD bresp", resp, RESP_SLVERR);
    wait_spi_idle(data);
    check_word("converter frames", adc_frames, 32'd3);
    check_word("synthesizer frames", pll_frames, 32'd1);
    check_spi_word("converter word", adc_last, word);

    // Back-pressure on both response channels
    for (int i = 0; i < 4; i++) begin
      val = rand_bits(32);
      axi_write(REG_GPIO_OUT, val, int'(rand_bits(3)) + 1, resp);
      check_resp("REG_GPIO_OUT bresp", resp, RESP_OKAY);
      axi_read(REG_GPIO_OUT, int'(rand_bits(3)) + 1, data, resp);
      check_word("REG_GPIO_OUT", data, val);
      check_resp("REG_GPIO_OUT rresp", resp, RESP_OKAY);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset generator
// 8 ns clock, active-low reset held for three rising edges

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

  always #4 clk_o = ~clk_o;

endmodule

/* m2k_ctrl_top.sv */
// Control plane top level
// AXI4-Lite front end, register decode and SPI engine in a chain

`timescale 1ns/1ps

module m2k_ctrl_top (
  input  logic                       s_axi_aclk_i,
  input  logic                       rst_n_i,
  input  logic                       s_axi_awvalid_i,
  output logic                       s_axi_awready_o,
  input  logic [m2k_pkg::ADDR_W-1:0] s_axi_awaddr_i,
  input  logic                       s_axi_wvalid_i,
  output logic                       s_axi_wready_o,
  input  logic [31:0]                s_axi_wdata_i,
  output logic                       s_axi_bvalid_o,
  input  logic                       s_axi_bready_i,
  output logic [1:0]                 s_axi_bresp_o,
  input  logic                       s_axi_arvalid_i,
  output logic                       s_axi_arready_o,
  input  logic [m2k_pkg::ADDR_W-1:0] s_axi_araddr_i,
  output logic                       s_axi_rvalid_o,
  input  logic                       s_axi_rready_i,
  output logic [31:0]                s_axi_rdata_o,
  output logic [1:0]                 s_axi_rresp_o,
  input  logic [31:0]                gpio_i_i,
  output logic [31:0]                gpio_o_o,
  output logic [31:0]                gpio_t_o,
  output logic                       ad9963_resetn_o,
  output logic                       en_power_analog_o,
  output logic                       ad9963_csn_o,
  output logic                       adf4360_cs_o,
  output logic                       spi_clk_o,
  output logic                       spi_sdio_o,
  output logic                       spi_sdio_t_o,
  input  logic                       spi_sdio_i
);

  import m2k_pkg::*;

  reg_req_t  reg_req;
  reg_rsp_t  reg_rsp;
  spi_req_t  spi_req;
  spi_stat_t spi_stat;

  // **************************************************
  // Stage 1, host bus
  // **************************************************

  m2k_axi_lite_slave i_axi_lite_slave (
    .s_axi_aclk_i    (s_axi_aclk_i),
    .rst_n_i         (rst_n_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .req_o           (reg_req),
    .rsp_i           (reg_rsp));

  // **************************************************
  // Stage 2 and 3, registers and SPI
  // **************************************************

  m2k_regmap i_regmap (
    .s_axi_aclk_i      (s_axi_aclk_i),
    .rst_n_i           (rst_n_i),
    .req_i             (reg_req),
    .rsp_o             (reg_rsp),
    .spi_req_o         (spi_req),
    .spi_stat_i        (spi_stat),
    .gpio_i_i          (gpio_i_i),
    .gpio_o_o          (gpio_o_o),
    .gpio_t_o          (gpio_t_o),
    .ad9963_resetn_o   (ad9963_resetn_o),
    .en_power_analog_o (en_power_analog_o));

  m2k_spi_engine i_spi_engine (
    .s_axi_aclk_i (s_axi_aclk_i),
    .rst_n_i      (rst_n_i),
    .spi_req_i    (spi_req),
    .spi_stat_o   (spi_stat),
    .ad9963_csn_o (ad9963_csn_o),
    .adf4360_cs_o (adf4360_cs_o),
    .spi_clk_o    (spi_clk_o),
    .spi_sdio_o   (spi_sdio_o),
    .spi_sdio_t_o (spi_sdio_t_o),
    .spi_sdio_i   (spi_sdio_i));

endmodule

/* m2k_spi_engine.sv */
// Shared three-wire SPI master
// Serializes 24-bit frames to the converter or the synthesizer and turns
// the data line around for converter reads

`timescale 1ns/1ps

module m2k_spi_engine (
  input  logic                s_axi_aclk_i,
  input  logic                rst_n_i,
  input  m2k_pkg::spi_req_t   spi_req_i,
  output m2k_pkg::spi_stat_t  spi_stat_o,
  output logic                ad9963_csn_o,
  output logic                adf4360_cs_o,
  output logic                spi_clk_o,
  output logic                spi_sdio_o,
  output logic                spi_sdio_t_o,
  input  logic                spi_sdio_i
);

  import m2k_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_SHIFT, ST_HOLD} state_t;

  state_t                    state_q;
  logic [SPI_DIV_W-1:0]      div_q;
  logic [SPI_BIT_W-1:0]      bit_q;
  logic [SPI_FRAME_BITS-1:0] shift_q;
  logic [7:0]                rx_q;
  logic [7:0]                rdata_q;
  logic                      clk_q;
  logic                      csn_q;
  logic                      pll_cs_q;
  logic                      sdio_t_q;
  logic                      rd_q;
  logic                      clk_rise;
  logic                      clk_fall;

  // SPI clock is low for the first SPI_DIV cycles of a bit, then high
  assign clk_rise = (state_q == ST_SHIFT) && (div_q == SPI_DIV_W'(SPI_DIV - 1));
  assign clk_fall = (state_q == ST_SHIFT) && (div_q == SPI_DIV_W'(2 * SPI_DIV - 1));

  // **************************************************
  // Frame sequencer
  // **************************************************

  always_ff @(posedge s_axi_aclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      div_q    <= '0;
      bit_q    <= '0;
      clk_q    <= 1'b0;
      csn_q    <= 1'b1;
      pll_cs_q <= 1'b1;
      sdio_t_q <= 1'b1;
      rd_q     <= 1'b0;
      rdata_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (spi_req_i.start) begin
            state_q  <= ST_SETUP;
            csn_q    <= spi_req_i.dev;
            pll_cs_q <= ~spi_req_i.dev;
            sdio_t_q <= 1'b0;
            rd_q     <= ~spi_req_i.dev & spi_req_i.word.adc.rw;
          end
        end
        // One cycle of select setup with the MSB already on the line
        ST_SETUP: begin
          state_q <= ST_SHIFT;
          div_q   <= '0;
          bit_q   <= '0;
        end
        ST_SHIFT: begin
          if (clk_rise) begin
            clk_q <= 1'b1;
          end
          if (clk_fall) begin
            clk_q <= 1'b0;
            div_q <= '0;
            bit_q <= bit_q + 1'b1;
            // Release the line once the instruction is out
            if (rd_q && (bit_q == SPI_BIT_W'(SPI_INSTR_BITS - 1))) begin
              sdio_t_q <= 1'b1;
            end
            if (bit_q == SPI_BIT_W'(SPI_FRAME_BITS - 1)) begin
              state_q <= ST_HOLD;
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        ST_HOLD: begin
          state_q  <= ST_IDLE;
          csn_q    <= 1'b1;
          pll_cs_q <= 1'b1;
          sdio_t_q <= 1'b1;
          if (rd_q) begin
            rdata_q <= rx_q;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Transmit on the falling edge, receive on the rising edge, MSB first
  always_ff @(posedge s_axi_aclk_i) begin
    if ((state_q == ST_IDLE) && spi_req_i.start) begin
      shift_q <= spi_req_i.word;
    end else if (clk_fall) begin
      shift_q <= {shift_q[SPI_FRAME_BITS-2:0], 1'b0};
    end
    if (clk_rise && rd_q && (bit_q >= SPI_BIT_W'(SPI_INSTR_BITS))) begin
      rx_q <= {rx_q[6:0], spi_sdio_i};
    end
  end

  assign ad9963_csn_o = csn_q;
  assign adf4360_cs_o = pll_cs_q;
  assign spi_clk_o    = clk_q;
  assign spi_sdio_o   = ~sdio_t_q & shift_q[SPI_FRAME_BITS-1];
  assign spi_sdio_t_o = sdio_t_q;

  assign spi_stat_o.busy  = (state_q != ST_IDLE);
  assign spi_stat_o.rdata = rdata_q;

endmodule

/* m2k_regmap.sv */
// Register decode stage
// GPIO output and tri-state registers, board control lines, GPIO input
// synchronizer and the SPI command and status registers

`timescale 1ns/1ps

module m2k_regmap (
  input  logic                s_axi_aclk_i,
  input  logic                rst_n_i,
  input  m2k_pkg::reg_req_t   req_i,
  output m2k_pkg::reg_rsp_t   rsp_o,
  output m2k_pkg::spi_req_t   spi_req_o,
  input  m2k_pkg::spi_stat_t  spi_stat_i,
  input  logic [31:0]         gpio_i_i,
  output logic [31:0]         gpio_o_o,
  output logic [31:0]         gpio_t_o,
  output logic                ad9963_resetn_o,
  output logic                en_power_analog_o
);

  import m2k_pkg::*;

  logic [31:0] gpio_out_q;
  logic [31:0] gpio_tri_q;
  logic [31:0] gpio_meta_q;
  logic [31:0] gpio_sync_q;
  logic [1:0]  ctrl_q;
  logic        spi_start_q;
  logic        spi_dev_q;
  spi_word_u   spi_word_q;
  logic        rsp_valid_q;
  logic        rsp_err_q;
  logic [31:0] rsp_rdata_q;
  logic [31:0] rd_data;
  logic        rd_err;
  logic        wr_err;
  logic        spi_busy;
  logic        spi_start;

  // The engine raises busy one cycle after start, so a pending start counts too
  assign spi_busy  = spi_stat_i.busy | spi_start_q;
  assign spi_start = req_i.wr && (req_i.addr == REG_SPI_CMD) && !spi_busy;

  // **************************************************
  // Address decode
  // **************************************************

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    wr_err  = 1'b0;
    case (req_i.addr)
      REG_ID: begin
        rd_data = CORE_ID;
        wr_err  = 1'b1;
      end
      REG_GPIO_OUT: rd_data = gpio_out_q;
      REG_GPIO_TRI: rd_data = gpio_tri_q;
      REG_GPIO_IN: begin
        rd_data = gpio_sync_q;
        wr_err  = 1'b1;
      end
      REG_CTRL: rd_data = {30'd0, ctrl_q};
      REG_SPI_CMD: begin
        rd_data = {7'd0, spi_dev_q, spi_word_q};
        wr_err  = spi_busy;
      end
      REG_SPI_STAT: begin
        rd_data = {16'd0, spi_stat_i.rdata, 7'd0, spi_stat_i.busy};
        wr_err  = 1'b1;
      end
      default: begin
        rd_err = 1'b1;
        wr_err = 1'b1;
      end
    endcase
  end

  always_ff @(posedge s_axi_aclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_out_q  <= '0;
      gpio_tri_q  <= '1;
      ctrl_q      <= '0;
      spi_start_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      spi_start_q <= spi_start;
      rsp_valid_q <= req_i.wr | req_i.rd;
      if (req_i.wr && !wr_err) begin
        case (req_i.addr)
          REG_GPIO_OUT: gpio_out_q <= req_i.wdata;
          REG_GPIO_TRI: gpio_tri_q <= req_i.wdata;
          REG_CTRL:     ctrl_q     <= req_i.wdata[1:0];
          default: ;
        endcase
      end
    end
  end

  // Two-stage synchronizer on the asynchronous pin inputs
  always_ff @(posedge s_axi_aclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
    end else begin
      gpio_meta_q <= gpio_i_i;
      gpio_sync_q <= gpio_meta_q;
    end
  end

  always_ff @(posedge s_axi_aclk_i) begin
    if (spi_start) begin
      spi_dev_q  <= req_i.wdata[24];
      spi_word_q <= req_i.wdata[23:0];
    end
    rsp_err_q   <= (req_i.wr & wr_err) | (req_i.rd & rd_err);
    rsp_rdata_q <= rd_data;
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.err   = rsp_err_q;
  assign rsp_o.rdata = rsp_rdata_q;

  assign spi_req_o.start = spi_start_q;
  assign spi_req_o.dev   = spi_dev_q;
  assign spi_req_o.word  = spi_word_q;

  assign gpio_o_o          = gpio_out_q;
  assign gpio_t_o          = gpio_tri_q;
  assign ad9963_resetn_o   = ctrl_q[0];
  assign en_power_analog_o = ctrl_q[1];

endmodule

/* m2k_axi_lite_slave.sv */
// AXI4-Lite slave front end
// Accepts one read or write at a time, issues a single-cycle register request
// and holds the B or R response until the host takes it

`timescale 1ns/1ps

module m2k_axi_lite_slave (
  input  logic                       s_axi_aclk_i,
  input  logic                       rst_n_i,
  input  logic                       s_axi_awvalid_i,
  output logic                       s_axi_awready_o,
  input  logic [m2k_pkg::ADDR_W-1:0] s_axi_awaddr_i,
  input  logic                       s_axi_wvalid_i,
  output logic                       s_axi_wready_o,
  input  logic [31:0]                s_axi_wdata_i,
  output logic                       s_axi_bvalid_o,
  input  logic                       s_axi_bready_i,
  output logic [1:0]                 s_axi_bresp_o,
  input  logic                       s_axi_arvalid_i,
  output logic                       s_axi_arready_o,
  input  logic [m2k_pkg::ADDR_W-1:0] s_axi_araddr_i,
  output logic                       s_axi_rvalid_o,
  input  logic                       s_axi_rready_i,
  output logic [31:0]                s_axi_rdata_o,
  output logic [1:0]                 s_axi_rresp_o,
  output m2k_pkg::reg_req_t          req_o,
  input  m2k_pkg::reg_rsp_t          rsp_i
);

  import m2k_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} state_t;

  state_t            state_q;
  logic              rd_q;
  logic [ADDR_W-1:0] addr_q;
  logic [31:0]       wdata_q;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [1:0]        resp_q;
  logic [31:0]       rdata_q;
  logic              rd_hs;
  logic              wr_hs;

  // Handshakes only happen in idle, so a held response blocks new ones
  // A read wins over a write arriving in the same cycle
  assign rd_hs = (state_q == ST_IDLE) && s_axi_arvalid_i;
  assign wr_hs = (state_q == ST_IDLE) && !s_axi_arvalid_i &&
                 s_axi_awvalid_i && s_axi_wvalid_i;

  assign s_axi_arready_o = rd_hs;
  assign s_axi_awready_o = wr_hs;
  assign s_axi_wready_o  = wr_hs;

  // **************************************************
  // Transaction FSM
  // **************************************************

  // Handshake edge, request cycle, then the regmap answer is captured,
  // so the response valid rises two edges after the handshake
  always_ff @(posedge s_axi_aclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      rd_q     <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (rd_hs || wr_hs) begin
            state_q <= ST_REQ;
            rd_q    <= rd_hs;
          end
        end
        ST_REQ: begin
          state_q <= ST_RESP;
        end
        ST_RESP: begin
          if (rsp_i.valid) begin
            bvalid_q <= ~rd_q;
            rvalid_q <= rd_q;
          end else if ((bvalid_q && s_axi_bready_i) || (rvalid_q && s_axi_rready_i)) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            state_q  <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk_i) begin
    if (rd_hs) begin
      addr_q <= s_axi_araddr_i;
    end else if (wr_hs) begin
      addr_q  <= s_axi_awaddr_i;
      wdata_q <= s_axi_wdata_i;
    end
    if ((state_q == ST_RESP) && rsp_i.valid) begin
      resp_q  <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
      rdata_q <= rsp_i.rdata;
    end
  end

  assign req_o.wr    = (state_q == ST_REQ) && !rd_q;
  assign req_o.rd    = (state_q == ST_REQ) && rd_q;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = wdata_q;

  assign s_axi_bvalid_o = bvalid_q;
  assign s_axi_bresp_o  = resp_q;
  assign s_axi_rvalid_o = rvalid_q;
  assign s_axi_rresp_o  = resp_q;
  assign s_axi_rdata_o  = rdata_q;

endmodule

/* m2k_pkg.sv */
// Shared definitions for the instrument control plane
// Register map, AXI response codes and SPI timing constants
// Register request and response types, SPI frame word and status types

package m2k_pkg;

  // **************************************************
  // Register map
  // **************************************************

  localparam int ADDR_W = 5;

  localparam logic [ADDR_W-1:0] REG_ID       = 5'h00;
  localparam logic [ADDR_W-1:0] REG_GPIO_OUT = 5'h04;
  localparam logic [ADDR_W-1:0] REG_GPIO_TRI = 5'h08;
  localparam logic [ADDR_W-1:0] REG_GPIO_IN  = 5'h0C;
  localparam logic [ADDR_W-1:0] REG_CTRL     = 5'h10;
  localparam logic [ADDR_W-1:0] REG_SPI_CMD  = 5'h14;
  localparam logic [ADDR_W-1:0] REG_SPI_STAT = 5'h18;

  // ASCII "M2KC"
  localparam logic [31:0] CORE_ID = 32'h4D32_4B43;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // **************************************************
  // SPI timing
  // **************************************************

  // System clocks per half SPI clock period
  localparam int SPI_DIV        = 4;
  localparam int SPI_FRAME_BITS = 24;
  // The converter instruction, after which a read turns the data line around
  localparam int SPI_INSTR_BITS = 16;

  localparam int SPI_DIV_W = $clog2(2 * SPI_DIV);
  localparam int SPI_BIT_W = $clog2(SPI_FRAME_BITS);

  // **************************************************
  // Types
  // **************************************************

  // Single-cycle register access from the AXI front end
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;
  } reg_req_t;

  typedef struct packed {
    logic        valid;
    logic        err;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Converter frame where a set rw bit means read
  typedef struct packed {
    logic        rw;
    logic [1:0]  wlen;
    logic [12:0] addr;
    logic [7:0]  data;
  } spi_adc_word_t;

  // Synthesizer latch word
  typedef struct packed {
    logic [21:0] latch;
    logic [1:0]  ctrl;
  } spi_pll_word_t;

  typedef union packed {
    spi_adc_word_t adc;
    spi_pll_word_t pll;
  } spi_word_u;

  // dev 0 selects the converter, 1 the synthesizer
  typedef struct packed {
    logic      start;
    logic      dev;
    spi_word_u word;
  } spi_req_t;

  typedef struct packed {
    logic       busy;
    logic [7:0] rdata;
  } spi_stat_t;

endpackage
